// ==== src.f ====
hdl/rv_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/hazard_unit.sv
hdl/top.sv
dv/tb_clock.sv
dv/top_asserts.sv
dv/tb_top.sv

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps

module tb_top import rv_pkg::*; ();

    localparam int imem_words = 64;
    localparam logic [2:0] f3_add = 3'd0;
    localparam logic [2:0] f3_slt = 3'd2;
    localparam logic [2:0] f3_xor = 3'd4;
    localparam logic [2:0] f3_or  = 3'd6;
    localparam logic [2:0] f3_and = 3'd7;
    localparam logic [2:0] f3_beq = 3'd0;
    localparam logic [2:0] f3_bne = 3'd1;
    localparam logic [6:0] f7_sub = 7'h20;

    logic        clk;
    logic        reset;
    logic        trigger;
    logic        imem_load;
    logic [5:0]  imem_addr;
    instr_t      imem_data;
    logic [31:0] a0;

    logic [31:0] prog [imem_words];
    int          prog_len = 0;
    int          budget_cycles = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic [31:0] expected;
    string       test_name;
    int          checks_requested = 0;
    int          checks_done = 0;

    tb_clock #(.period(8.0)) u_clock (.clk(clk));

    top #(
        .imem_words(imem_words),
        .dmem_words(64)
    ) u_top (
        .clk(clk),
        .reset(reset),
        .trigger(trigger),
        .imem_load(imem_load),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .a0(a0)
    );

    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] add_imm(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_if(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                              input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic void emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endfunction

    function automatic void pad_nops(input int count);
        for (int i = 0; i < count; i++) begin
            emit(add_imm(0, 0, 12'h000));
        end
    endfunction

    // ISA level interpreter that runs until the jump to itself
    function automatic logic [31:0] reference_a0();
        logic [31:0] x [32];
        logic [31:0] dm [64];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] w;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        bit          done;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dm[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w       = prog[pc[7:2]];
            rd      = w[11:7];
            rs1     = w[19:15];
            rs2     = w[24:20];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 32'd4;
            case (w[6:0])
                7'b0110011: begin
                    case ({w[31:25], w[14:12]})
                        {7'h00, f3_add}: x[rd] = x[rs1] + x[rs2];
                        {f7_sub, f3_add}: x[rd] = x[rs1] - x[rs2];
                        {7'h00, f3_and}: x[rd] = x[rs1] & x[rs2];
                        {7'h00, f3_or}:  x[rd] = x[rs1] | x[rs2];
                        {7'h00, f3_xor}: x[rd] = x[rs1] ^ x[rs2];
                        {7'h00, f3_slt}: x[rd] = ($signed(x[rs1]) < $signed(x[rs2])) ? 1 : 0;
                        default: ;
                    endcase
                end
                7'b0010011: x[rd] = x[rs1] + imm_i;
                7'b0110111: x[rd] = {w[31:12], 12'b0};
                7'b0000011: begin
                    addr  = x[rs1] + imm_i;
                    x[rd] = dm[addr[7:2]];
                end
                7'b0100011: begin
                    addr           = x[rs1] + imm_s;
                    dm[addr[7:2]] = x[rs2];
                end
                7'b1100011: begin
                    if ((w[14:12] == f3_beq && x[rs1] == x[rs2]) ||
                        (w[14:12] == f3_bne && x[rs1] != x[rs2])) begin
                        next_pc = pc + imm_b;
                    end
                end
                7'b1101111: begin
                    if (imm_j == 32'd0) begin
                        done = 1'b1;
                    end else begin
                        x[rd]   = pc + 32'd4;
                        next_pc = pc + imm_j;
                    end
                end
                default: ;
            endcase
            x[0]  = '0;
            pc    = next_pc;
            steps++;
        end
        return x[10];
    endfunction

    task automatic alu_program();
        prog_len = 0;
        emit(add_imm(1, 0, 12'h123));
        emit(add_imm(2, 0, 12'hfaa));
        emit(upper_imm(3, 20'habcde));
        pad_nops(3);
        emit(alu_rr(7'h00, f3_add, 4, 1, 2));
        emit(alu_rr(f7_sub, f3_add, 5, 1, 2));
        emit(alu_rr(7'h00, f3_and, 6, 3, 2));
        emit(alu_rr(7'h00, f3_or, 7, 1, 3));
        emit(alu_rr(7'h00, f3_xor, 8, 2, 3));
        emit(alu_rr(7'h00, f3_slt, 9, 2, 1));
        pad_nops(3);
        emit(alu_rr(7'h00, f3_add, 10, 4, 5));
        emit(alu_rr(7'h00, f3_xor, 11, 6, 7));
        emit(alu_rr(7'h00, f3_or, 12, 8, 9));
        pad_nops(3);
        emit(alu_rr(7'h00, f3_xor, 10, 10, 11));
        pad_nops(3);
        emit(alu_rr(7'h00, f3_add, 10, 10, 12));
        emit(jump_link(0, 21'd0));
    endtask

    // Every instruction consumes the one right before it
    task automatic forwarding_program();
        prog_len = 0;
        emit(add_imm(1, 0, 12'h005));
        emit(add_imm(2, 1, 12'h007));
        emit(alu_rr(7'h00, f3_add, 3, 2, 1));
        emit(alu_rr(f7_sub, f3_add, 10, 3, 2));
        emit(alu_rr(7'h00, f3_xor, 10, 10, 3));
        emit(add_imm(10, 10, 12'hffd));
        emit(upper_imm(4, 20'h12345));
        emit(alu_rr(7'h00, f3_or, 10, 10, 4));
        emit(alu_rr(7'h00, f3_add, 10, 10, 10));
        emit(jump_link(0, 21'd0));
    endtask

    task automatic memory_program();
        prog_len = 0;
        emit(upper_imm(1, 20'hdeadb));
        emit(add_imm(1, 1, 12'h2ef));
        emit(add_imm(2, 0, 12'h040));
        emit(store_word(1, 2, 12'h008));
        pad_nops(1);
        emit(load_word(3, 2, 12'h008));
        pad_nops(1);
        emit(add_imm(10, 3, 12'h000));
        emit(jump_link(0, 21'd0));
    endtask

    // The skipped instructions would all change a0 if they ran
    task automatic branch_program();
        prog_len = 0;
        emit(add_imm(10, 0, 12'h001));
        emit(add_imm(1, 0, 12'h003));
        emit(add_imm(2, 0, 12'h003));
        emit(branch_if(f3_beq, 1, 2, 13'd12));
        emit(add_imm(10, 10, 12'h064));
        emit(add_imm(10, 10, 12'h0c8));
        emit(add_imm(10, 10, 12'h002));
        emit(branch_if(f3_bne, 1, 2, 13'd8));
        emit(add_imm(10, 10, 12'h004));
        emit(add_imm(3, 0, 12'h005));
        emit(branch_if(f3_bne, 1, 3, 13'd12));
        emit(add_imm(10, 10, 12'h040));
        emit(add_imm(10, 10, 12'h080));
        emit(branch_if(f3_beq, 1, 3, 13'd8));
        emit(add_imm(10, 10, 12'h008));
        emit(jump_link(5, 21'd12));
        emit(add_imm(10, 10, 12'h100));
        emit(add_imm(10, 10, 12'h200));
        emit(alu_rr(7'h00, f3_add, 10, 10, 5));
        emit(jump_link(0, 21'd0));
    endtask

    task automatic random_program();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        prog_len = 0;
        for (int i = 0; i < 20; i++) begin
            kind = $urandom_range(3, 0);
            rd   = 5'($urandom_range(15, 8));
            rs1  = 5'($urandom_range(15, 0));
            rs2  = 5'($urandom_range(15, 0));
            imm  = 12'($urandom());
            case (kind)
                0: emit(add_imm(rd, rs1, imm));
                1: emit(alu_rr(7'h00, f3_add, rd, rs1, rs2));
                2: emit(alu_rr(f7_sub, f3_add, rd, rs1, rs2));
                default: emit(alu_rr(7'h00, f3_xor, rd, rs1, rs2));
            endcase
        end
        // Sum every random destination into a0 so that each result shows up there
        for (int r = 8; r < 16; r++) begin
            if (r != 10) begin
                emit(alu_rr(7'h00, f3_add, 10, 10, 5'(r)));
            end
        end
        emit(jump_link(0, 21'd0));
    endtask

    task automatic run_program(input string name, input bit start);
        int wait_cycles;
        wait_cycles = 4 * prog_len + 30;
        budget_cycles += 10 + prog_len + 2 + wait_cycles;
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < prog_len; i++) begin
            imem_load = 1'b1;
            imem_addr = 6'(i);
            imem_data = prog[i];
            @(negedge clk);
        end
        imem_load = 1'b0;
        if (start) begin
            trigger = 1'b1;
            @(negedge clk);
            trigger = 1'b0;
        end
        repeat (wait_cycles) @(negedge clk);
        // Without a trigger the pc never leaves zero and a0 keeps its reset value
        expected  = start ? reference_a0() : 32'h0;
        test_name = name;
        checks_requested++;
        wait (checks_done == checks_requested);
    endtask

    initial begin
        forever begin
            wait (checks_done != checks_requested);
            if (a0 !== expected) begin
                $display("error a0 expected 0x%08h got 0x%08h in test %s",
                         expected, a0, test_name);
                fail_count++;
            end else begin
                $display("test %s passed with a0 0x%08h", test_name, a0);
                pass_count++;
            end
            checks_done++;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < budget_cycles + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run was still going after %0d cycles", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        trigger   = 1'b0;
        imem_load = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        void'($urandom(32'h7b22));
        @(negedge clk);
        alu_program();
        run_program("alu", 1'b1);
        forwarding_program();
        run_program("forwarding", 1'b1);
        memory_program();
        run_program("store_load", 1'b1);
        branch_program();
        run_program("branches", 1'b1);
        random_program();
        run_program("random", 1'b1);
        alu_program();
        run_program("no_trigger", 1'b0);
        $display("tests passed %0d failed %0d, assertion failures %0d",
                 pass_count, fail_count, u_top.u_top_asserts.failures);
        if (fail_count == 0 && u_top.u_top_asserts.failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/top_asserts.sv ====
`timescale 1ns/100ps

module top_asserts import rv_pkg::*; (
    input logic     clk,
    input logic     reset,
    input de_t      de,
    input em_t      em,
    input mw_t      mw,
    input fwd_sel_e fwd_a,
    input logic     flush
);

    int unsigned failures = 0;

    // No store or register write may leak out of a reset cycle
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!em.mem_write && !mw.reg_write))
    else begin
        $error("a store or register write was active during or just after reset");
        failures++;
    end

    no_forward_from_x0: assert property (@(posedge clk) disable iff (reset)
        !(fwd_a == fwd_mem && em.rd == 5'd0))
    else begin
        $error("operand a was forwarded from the memory stage for register zero");
        failures++;
    end

    // The instruction behind a taken branch never reaches execute
    flush_clears_decode: assert property (@(posedge clk) disable iff (reset)
        flush |-> ##2 !de.valid)
    else begin
        $error("decode/execute register still valid two cycles after a flush");
        failures++;
    end

endmodule

bind top top_asserts u_top_asserts (
    .clk(clk),
    .reset(reset),
    .de(de),
    .em(em),
    .mw(mw),
    .fwd_a(fwd_a),
    .flush(flush)
);

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter real period = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2.0) clk = ~clk;
        end
    end

endmodule

// ==== hdl/top.sv ====
`timescale 1ns/100ps

module top import rv_pkg::*; #(
    parameter int imem_words = 64,
    parameter int dmem_words = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          trigger,
    input  logic                          imem_load,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  instr_t                        imem_data,
    output logic [31:0]                   a0
);

    fd_t         fd;
    de_t         de;
    em_t         em;
    mw_t         mw;
    wb_t         wb;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        flush;

    fetch #(
        .imem_words(imem_words)
    ) u_fetch (
        .clk(clk),
        .reset(reset),
        .trigger(trigger),
        .imem_load(imem_load),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .flush(flush),
        .redirect_pc(redirect_pc),
        .fd(fd)
    );

    decode u_decode (
        .clk(clk),
        .reset(reset),
        .fd(fd),
        .flush(flush),
        .mw(mw),
        .de(de),
        .wb(wb),
        .a0(a0)
    );

    execute u_execute (
        .clk(clk),
        .reset(reset),
        .de(de),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .wb(wb),
        .em(em),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    memory #(
        .dmem_words(dmem_words)
    ) u_memory (
        .clk(clk),
        .reset(reset),
        .em(em),
        .mw(mw)
    );

    hazard_unit u_hazard_unit (
        .de(de),
        .em(em),
        .wb(wb),
        .redirect(redirect),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .flush(flush)
    );

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit import rv_pkg::*; (
    input  de_t      de,
    input  em_t      em,
    input  wb_t      wb,
    input  logic     redirect,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output logic     flush
);

    // The younger producer in memory takes priority over writeback
    function automatic fwd_sel_e pick(input logic [4:0] rs, input em_t m, input wb_t w);
        if (rs == 5'd0) begin
            return fwd_none;
        end else if (m.reg_write && m.rd == rs) begin
            return fwd_mem;
        end else if (w.reg_write && w.rd == rs) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd_a = pick(de.rs1, em, wb);
    assign fwd_b = pick(de.rs2, em, wb);
    assign flush = redirect;

endmodule

// ==== hdl/memory.sv ====
`timescale 1ns/100ps

module memory import rv_pkg::*; #(
    parameter int dmem_words = 64
) (
    input  logic clk,
    input  logic reset,
    input  em_t  em,
    output mw_t  mw
);

    localparam int addr_bits = $clog2(dmem_words);

    logic [31:0]          dmem [dmem_words];
    logic [addr_bits-1:0] word_addr;

    // The low two address bits are ignored because the memory is word addressed
    assign word_addr = em.alu_result[addr_bits+1:2];

    always_ff @(posedge clk) begin
        if (em.mem_write) begin
            dmem[word_addr] <= em.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mw.reg_write <= 1'b0;
        end else begin
            mw.reg_write <= em.reg_write;
        end
        mw.result_src <= em.result_src;
        mw.alu_result <= em.alu_result;
        mw.mem_data   <= dmem[word_addr];
        mw.pc4        <= em.pc4;
        mw.rd         <= em.rd;
    end

endmodule

// ==== hdl/execute.sv ====
`timescale 1ns/100ps

module execute import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  de_t         de,
    input  fwd_sel_e    fwd_a,
    input  fwd_sel_e    fwd_b,
    input  wb_t         wb,
    output em_t         em,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] result;
    logic        equal;

    function automatic logic [31:0] forward(input fwd_sel_e    sel,
                                            input logic [31:0] reg_val,
                                            input logic [31:0] mem_val,
                                            input logic [31:0] wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = forward(fwd_a, de.rs1_val, em.alu_result, wb.result);
    assign src_b = forward(fwd_b, de.rs2_val, em.alu_result, wb.result);
    assign alu_b = de.ctrl.alu_src_imm ? de.imm : src_b;

    always_comb begin
        case (de.ctrl.alu_op)
            alu_add:   alu_result = src_a + alu_b;
            alu_sub:   alu_result = src_a - alu_b;
            alu_and:   alu_result = src_a & alu_b;
            alu_or:    alu_result = src_a | alu_b;
            alu_xor:   alu_result = src_a ^ alu_b;
            alu_slt:   alu_result = {31'b0, $signed(src_a) < $signed(alu_b)};
            alu_passb: alu_result = alu_b;
            default:   alu_result = '0;
        endcase
    end

    // The link value rides in alu_result so it can be forwarded like any other
    assign result = de.ctrl.jump ? de.pc4 : alu_result;

    assign equal       = src_a == src_b;
    assign redirect    = de.valid &&
                         ((de.ctrl.branch && (equal ^ de.ctrl.branch_ne)) || de.ctrl.jump);
    assign redirect_pc = de.pc + de.imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            em.reg_write <= 1'b0;
            em.mem_write <= 1'b0;
        end else begin
            em.reg_write <= de.valid && de.ctrl.reg_write;
            em.mem_write <= de.valid && de.ctrl.mem_write;
        end
        em.result_src <= de.ctrl.result_src;
        em.alu_result <= result;
        em.store_data <= src_b;
        em.pc4        <= de.pc4;
        em.rd         <= de.rd;
    end

endmodule

// ==== hdl/decode.sv ====
`timescale 1ns/100ps

module decode import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  fd_t         fd,
    input  logic        flush,
    input  mw_t         mw,
    output de_t         de,
    output wb_t         wb,
    output logic [31:0] a0
);

    logic [31:0] regs [32];
    instr_t      instr;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] result;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;

    assign instr = fd.instr;

    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm, 12'b0};
    assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        if (fd.valid) begin
            case (instr.r_fmt.opcode)
                op: begin
                    ctrl.reg_write = 1'b1;
                    case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
                        {7'h00, 3'b000}: ctrl.alu_op = alu_add;
                        {7'h20, 3'b000}: ctrl.alu_op = alu_sub;
                        {7'h00, 3'b111}: ctrl.alu_op = alu_and;
                        {7'h00, 3'b110}: ctrl.alu_op = alu_or;
                        {7'h00, 3'b100}: ctrl.alu_op = alu_xor;
                        {7'h00, 3'b010}: ctrl.alu_op = alu_slt;
                        default:         ctrl = '0;
                    endcase
                end
                op_imm: begin
                    if (instr.i_fmt.funct3 == 3'b000) begin
                        ctrl.reg_write   = 1'b1;
                        ctrl.alu_src_imm = 1'b1;
                        imm              = imm_i;
                    end
                end
                lui: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_op      = alu_passb;
                    ctrl.alu_src_imm = 1'b1;
                    imm              = imm_u;
                end
                load: begin
                    if (instr.i_fmt.funct3 == 3'b010) begin
                        ctrl.reg_write   = 1'b1;
                        ctrl.result_src  = res_mem;
                        ctrl.alu_src_imm = 1'b1;
                        imm              = imm_i;
                    end
                end
                store: begin
                    if (instr.s_fmt.funct3 == 3'b010) begin
                        ctrl.mem_write   = 1'b1;
                        ctrl.alu_src_imm = 1'b1;
                        imm              = imm_s;
                    end
                end
                branch: begin
                    // Only beq (000) and bne (001) are decoded
                    if (instr.b_fmt.funct3[2:1] == 2'b00) begin
                        ctrl.branch    = 1'b1;
                        ctrl.branch_ne = instr.b_fmt.funct3[0];
                        imm            = imm_b;
                    end
                end
                jal: begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.result_src = res_pc4;
                    ctrl.jump       = 1'b1;
                    imm             = imm_j;
                end
                default: ctrl = '0;
            endcase
        end
    end

    always_comb begin
        case (mw.result_src)
            res_mem: result = mw.mem_data;
            res_pc4: result = mw.pc4;
            default: result = mw.alu_result;
        endcase
    end

    assign wb = '{reg_write: mw.reg_write, rd: mw.rd, result: result};

    // A register written this cycle reads back with its new value
    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (mw.reg_write && mw.rd == idx) begin
            return result;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_val = read_reg(instr.r_fmt.rs1);
        rs2_val = read_reg(instr.r_fmt.rs2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (mw.reg_write && mw.rd != 5'd0) begin
            regs[mw.rd] <= result;
        end
    end

    assign a0 = regs[10];

    always_ff @(posedge clk) begin
        if (reset) begin
            de.valid <= 1'b0;
            de.ctrl  <= '0;
        end else begin
            de.valid <= fd.valid && !flush;
            de.ctrl  <= ctrl;
        end
        de.pc      <= fd.pc;
        de.pc4     <= fd.pc4;
        de.imm     <= imm;
        de.rs1_val <= rs1_val;
        de.rs2_val <= rs2_val;
        de.rs1     <= instr.r_fmt.rs1;
        de.rs2     <= instr.r_fmt.rs2;
        de.rd      <= instr.r_fmt.rd;
    end

endmodule

// ==== hdl/fetch.sv ====
`timescale 1ns/100ps

module fetch import rv_pkg::*; #(
    parameter int imem_words = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          trigger,
    input  logic                          imem_load,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  instr_t                        imem_data,
    input  logic                          flush,
    input  logic [31:0]                   redirect_pc,
    output fd_t                           fd
);

    localparam int addr_bits = $clog2(imem_words);

    instr_t      imem [imem_words];
    logic [31:0] pc;
    logic        started;
    instr_t      instr;

    always_ff @(posedge clk) begin
        if (imem_load) begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign instr = imem[pc[addr_bits+1:2]];

    // The pc stays at zero until trigger has been seen once
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            started  <= 1'b0;
            fd.valid <= 1'b0;
        end else begin
            if (trigger) begin
                started <= 1'b1;
            end
            if (flush) begin
                pc       <= redirect_pc;
                fd.valid <= 1'b0;
            end else if (started) begin
                pc       <= pc + 32'd4;
                fd.valid <= 1'b1;
            end else begin
                fd.valid <= 1'b0;
            end
        end
        fd.instr <= instr;
        fd.pc    <= pc;
        fd.pc4   <= pc + 32'd4;
    end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_passb
    } alu_op_e;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc4
    } result_src_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, read through whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_e result_src;
        alu_op_e     alu_op;
        logic        alu_src_imm;
        logic        branch;
        logic        branch_ne;
        logic        jump;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        instr_t      instr;
        logic [31:0] pc;
        logic [31:0] pc4;
    } fd_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } de_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_e result_src;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [31:0] pc4;
        logic [4:0]  rd;
    } em_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic [31:0] alu_result;
        logic [31:0] mem_data;
        logic [31:0] pc4;
        logic [4:0]  rd;
    } mw_t;

    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] result;
    } wb_t;

endpackage
